//--- sources.f
src/bpu_kind_pkg.sv
src/bpu_cfg_pkg.sv
src/pc_hash.sv
src/btb.sv
src/ras.sv
src/cpht.sv
src/npc_predictor.sv
src/bpu_top.sv
verification/tb_bpu.sv

//--- Makefile
# Verilator build and run of the predictor testbench

VERILATOR ?= verilator
TOP       ?= tb_bpu
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= *** TEST PASSED ***

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- verification/tb_bpu.sv
`timescale 1ns/1ps

module tb_bpu;
    import bpu_kind_pkg::*;
    import bpu_cfg_pkg::*;

    localparam int aw    = 30;
    localparam int gw    = 8;
    localparam int sl    = 16;
    localparam int depth = 1 << gw;

    logic          clk;
    logic          rstn;
    logic          stall;
    logic          update_en;
    logic [aw-1:0] npc_ex;
    logic [gw-1:0] pc_ex_bh_hashed;
    logic [gw-1:0] pc_ex_hashed;
    branch_kind_t  kind_ex;
    logic          taken_ex;
    logic          choice_real;
    logic [aw-1:0] ret_pc_ex;
    choice_ctr_t   choice_pdch_ex;
    logic          mis_pdc;
    logic [aw-1:0] npc_pdc;
    branch_kind_t  kind_pdc;
    logic          taken_pdc;
    logic          choice_btb_ras;
    choice_ctr_t   choice_pdch;
    logic [aw-1:0] pc_reg;
    logic [gw-1:0] pc_hashed;
    logic [gw-1:0] pc_bh_hashed;

    // scoreboard state
    logic [aw-1:0] btb_tgt [depth];
    logic          btb_val [depth];
    choice_ctr_t   ch_ctr [depth];
    logic          ch_val [depth];
    logic [aw-1:0] ras_mem [sl];
    logic [3:0]    ras_cmt;
    logic [3:0]    ras_spec;
    logic [gw-1:0] ghr_m;
    logic [31:0]   lcg_state;

    bpu_top #(
        .addr_width(aw),
        .gh_width  (gw),
        .stack_len (sl)
    ) UUT (
        .clk            (clk),
        .rstn           (rstn),
        .stall          (stall),
        .update_en      (update_en),
        .npc_ex         (npc_ex),
        .pc_ex_bh_hashed(pc_ex_bh_hashed),
        .pc_ex_hashed   (pc_ex_hashed),
        .kind_ex        (kind_ex),
        .taken_ex       (taken_ex),
        .choice_real    (choice_real),
        .ret_pc_ex      (ret_pc_ex),
        .choice_pdch_ex (choice_pdch_ex),
        .mis_pdc        (mis_pdc),
        .npc_pdc        (npc_pdc),
        .kind_pdc       (kind_pdc),
        .taken_pdc      (taken_pdc),
        .choice_btb_ras (choice_btb_ras),
        .choice_pdch    (choice_pdch),
        .pc_reg         (pc_reg),
        .pc_hashed      (pc_hashed),
        .pc_bh_hashed   (pc_bh_hashed)
    );

    always #5 clk = ~clk;

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [aw-1:0] rand_addr();
        logic [31:0] r;
        r = lcg_next();
        return r[31:2];
    endfunction

    // first word of the next aligned pair
    function automatic logic [aw-1:0] fall_through(logic [aw-1:0] a);
        return {a[aw-1:1] + (aw-1)'(1), 1'b0};
    endfunction

    // xor of the 8-bit slices with the top slice zero padded
    function automatic logic [gw-1:0] fold(logic [aw-1:0] a);
        logic [39:0] ext;
        ext = {10'b0, a};
        return ext[7:0] ^ ext[15:8] ^ ext[23:16] ^ ext[31:24] ^ ext[39:32];
    endfunction

    function automatic choice_ctr_t read_choice(logic [aw-1:0] pc);
        logic [gw-1:0] h;
        h = fold(pc);
        return ch_val[h] ? ch_ctr[h] : choice_init;
    endfunction

    function automatic logic [aw-1:0] expect_npc(logic [aw-1:0] pc, branch_kind_t kind,
                                                 logic taken, logic stl);
        logic [gw-1:0] bh;
        logic [aw-1:0] seq;
        logic [aw-1:0] btb_or_seq;
        logic [aw-1:0] res;
        choice_ctr_t   ctr;
        bh = fold(pc) ^ ghr_m;
        seq = fall_through(pc);
        btb_or_seq = btb_val[bh] ? btb_tgt[bh] : seq;
        ctr = read_choice(pc);
        case (kind)
            direct_jump, indirect_jump, jump, call: res = btb_or_seq;
            ret: res = ctr[1] ? btb_or_seq : ras_mem[ras_spec - 4'd1];
            default: res = seq;
        endcase
        if (!taken) begin
            res = seq;
        end
        if (stl) begin
            res = pc;
        end
        return res;
    endfunction

    // one resolved branch from execute
    // the models follow the same edge
    task automatic train(branch_kind_t kind, logic [aw-1:0] pc, logic taken,
                         logic [aw-1:0] target, logic creal, logic mis);
        logic [gw-1:0] h;
        logic [gw-1:0] bh;
        choice_ctr_t   ctr;
        h = fold(pc);
        bh = h ^ ghr_m;
        ctr = read_choice(pc);
        @(negedge clk);
        taken_pdc = 1'b0;
        kind_pdc = not_jump;
        stall = 1'b0;
        update_en = 1'b1;
        kind_ex = kind;
        taken_ex = taken;
        npc_ex = target;
        ret_pc_ex = fall_through(pc);
        pc_ex_hashed = h;
        pc_ex_bh_hashed = bh;
        choice_pdch_ex = ctr;
        choice_real = creal;
        mis_pdc = mis;
        if (kind != not_jump) begin
            btb_tgt[bh] = target;
            btb_val[bh] = 1'b1;
            ghr_m = {ghr_m[gw-2:0], taken};
        end
        if (kind == ret) begin
            if (creal && ctr != 2'd3) begin
                ctr = ctr + 2'd1;
            end else if (!creal && ctr != 2'd0) begin
                ctr = ctr - 2'd1;
            end
            ch_ctr[h] = ctr;
            ch_val[h] = 1'b1;
            ras_cmt = ras_cmt - 4'd1;
        end
        if (kind == call) begin
            ras_mem[ras_cmt] = fall_through(pc);
            ras_cmt = ras_cmt + 4'd1;
            ras_spec = ras_spec + 4'd1;
        end
        if (mis) begin
            ras_spec = ras_cmt;
        end
    endtask

    task automatic predict(logic [aw-1:0] pc, branch_kind_t kind, logic taken, logic stl);
        logic [aw-1:0] exp_npc;
        choice_ctr_t   ctr;
        exp_npc = expect_npc(pc, kind, taken, stl);
        ctr = read_choice(pc);
        @(negedge clk);
        update_en = 1'b0;
        mis_pdc = 1'b0;
        pc_reg = pc;
        kind_pdc = kind;
        taken_pdc = taken;
        stall = stl;
        #1;
        check_value("pc_hashed", 32'(pc_hashed), 32'(fold(pc)));
        check_value("pc_bh_hashed", 32'(pc_bh_hashed), 32'(fold(pc) ^ ghr_m));
        check_value("choice_pdch", 32'(choice_pdch), 32'(ctr));
        check_value("choice_btb_ras", 32'(choice_btb_ras), 32'(ctr[1]));
        check_value("npc_pdc", 32'(npc_pdc), 32'(exp_npc));
        // popped at the coming rising edge
        if (!stl && taken && kind == ret) begin
            ras_spec = ras_spec - 4'd1;
        end
    endtask

    task automatic reset_defaults_test();
        logic [aw-1:0] pc;
        logic [31:0]   r;
        branch_kind_t  kind;
        for (int i = 0; i < 24; i++) begin
            pc = rand_addr();
            r = lcg_next();
            kind = branch_kind_t'(i[2:0]);
            // a taken ret would read an empty stack
            predict(pc, kind, r[0] && kind != ret, 1'b0);
            check_value("npc_pdc", 32'(npc_pdc), 32'(fall_through(pc)));
            check_value("choice_pdch", 32'(choice_pdch), 32'd1);
            predict(pc, kind, r[1], 1'b1);
            check_value("npc_pdc", 32'(npc_pdc), 32'(pc));
        end
    endtask

    task automatic hash_history_test();
        logic [31:0] r;
        for (int i = 0; i < 16; i++) begin
            r = lcg_next();
            train(r[3] ? jump : direct_jump, rand_addr(), r[0], rand_addr(), 1'b0, 1'b0);
            predict(rand_addr(), not_jump, 1'b0, 1'b0);
        end
    endtask

    task automatic btb_train_test();
        branch_kind_t  kinds [4];
        logic [aw-1:0] pc;
        logic [aw-1:0] tgt;
        kinds = '{direct_jump, jump, indirect_jump, call};
        // all-ones history stays put under taken updates
        for (int i = 0; i < gw; i++) begin
            train(direct_jump, rand_addr(), 1'b1, rand_addr(), 1'b0, 1'b0);
        end
        for (int i = 0; i < 4; i++) begin
            pc = rand_addr();
            tgt = rand_addr();
            train(kinds[i], pc, 1'b1, tgt, 1'b0, 1'b0);
            predict(pc, kinds[i], 1'b1, 1'b0);
            check_value("npc_pdc", 32'(npc_pdc), 32'(tgt));
        end
        pc = rand_addr();
        for (int i = 0; i < 64 && btb_val[fold(pc) ^ ghr_m]; i++) begin
            pc = rand_addr();
        end
        predict(pc, jump, 1'b1, 1'b0);
        check_value("npc_pdc", 32'(npc_pdc), 32'(fall_through(pc)));
    endtask

    task automatic ras_lifo_test();
        logic [aw-1:0] pcs [3];
        for (int i = 0; i < 3; i++) begin
            pcs[i] = rand_addr();
            train(call, pcs[i], 1'b1, rand_addr(), 1'b0, 1'b0);
        end
        predict(rand_addr(), ret, 1'b1, 1'b1);
        for (int i = 2; i >= 0; i--) begin
            predict(rand_addr(), ret, 1'b1, 1'b0);
            check_value("npc_pdc", 32'(npc_pdc), 32'(fall_through(pcs[i])));
        end
    endtask

    task automatic mispredict_test();
        train(not_jump, rand_addr(), 1'b0, '0, 1'b0, 1'b1);
        predict(rand_addr(), ret, 1'b1, 1'b0);
        predict(rand_addr(), ret, 1'b1, 1'b0);
        train(not_jump, rand_addr(), 1'b0, '0, 1'b0, 1'b1);
        predict(rand_addr(), ret, 1'b1, 1'b0);
        train(ret, rand_addr(), 1'b1, rand_addr(), 1'b0, 1'b1);
        predict(rand_addr(), ret, 1'b1, 1'b0);
    endtask

    task automatic choice_counter_test();
        logic [aw-1:0] pc;
        logic [aw-1:0] tgt;
        int            cycles;
        pc = rand_addr();
        tgt = rand_addr();
        train(jump, pc, 1'b1, tgt, 1'b0, 1'b0);
        for (int i = 0; i < 4; i++) begin
            train(ret, pc, 1'b1, tgt, 1'b1, 1'b0);
            predict(pc, not_jump, 1'b0, 1'b0);
        end
        check_value("choice_pdch", 32'(choice_pdch), 32'd3);
        predict(pc, ret, 1'b1, 1'b0);
        check_value("npc_pdc", 32'(npc_pdc), 32'(tgt));
        // step down until the ras is trusted again
        cycles = 0;
        while (choice_btb_ras) begin
            if (cycles > 8) begin
                $display("timeout: choice_btb_ras never fell while stepping the counter down");
                abort_run();
            end
            train(ret, pc, 1'b1, tgt, 1'b0, 1'b0);
            predict(pc, not_jump, 1'b0, 1'b0);
            cycles++;
        end
        check_value("choice_pdch", 32'(choice_pdch), 32'd1);
        predict(pc, ret, 1'b1, 1'b0);
    endtask

    // guard against a stuck run
    initial begin
        #50000;
        $display("simulation ran past its time limit");
        abort_run();
    end

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        stall = 1'b0;
        update_en = 1'b0;
        npc_ex = '0;
        pc_ex_bh_hashed = '0;
        pc_ex_hashed = '0;
        kind_ex = not_jump;
        taken_ex = 1'b0;
        choice_real = 1'b0;
        ret_pc_ex = '0;
        choice_pdch_ex = '0;
        mis_pdc = 1'b0;
        kind_pdc = not_jump;
        taken_pdc = 1'b0;
        pc_reg = '0;
        lcg_state = 32'h2233_bf18;
        btb_val = '{default: 1'b0};
        ch_val = '{default: 1'b0};
        ras_cmt = '0;
        ras_spec = '0;
        ghr_m = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        reset_defaults_test();
        hash_history_test();
        btb_train_test();
        ras_lifo_test();
        mispredict_test();
        choice_counter_test();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

//--- src/bpu_top.sv
`timescale 1ns/1ps

module bpu_top #(
    parameter int addr_width = bpu_cfg_pkg::default_addr_width,
    parameter int gh_width   = bpu_cfg_pkg::default_gh_width,
    parameter int stack_len  = bpu_cfg_pkg::default_stack_len
) (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       stall,
    input  logic                       update_en,
    input  logic [addr_width-1:0]      npc_ex,
    input  logic [gh_width-1:0]        pc_ex_bh_hashed,
    input  logic [gh_width-1:0]        pc_ex_hashed,
    input  bpu_kind_pkg::branch_kind_t kind_ex,
    input  logic                       taken_ex,
    input  logic                       choice_real,
    input  logic [addr_width-1:0]      ret_pc_ex,
    input  bpu_cfg_pkg::choice_ctr_t   choice_pdch_ex,
    input  logic                       mis_pdc,
    output logic [addr_width-1:0]      npc_pdc,
    input  bpu_kind_pkg::branch_kind_t kind_pdc,
    input  logic                       taken_pdc,
    output logic                       choice_btb_ras,
    output bpu_cfg_pkg::choice_ctr_t   choice_pdch,
    input  logic [addr_width-1:0]      pc_reg,
    output logic [gh_width-1:0]        pc_hashed,
    output logic [gh_width-1:0]        pc_bh_hashed
);

    // indices for the current fetch address, carried down the pipe
    pc_hash #(
        .addr_width(addr_width),
        .gh_width  (gh_width)
    ) u_pc_hash (
        .clk         (clk),
        .rstn        (rstn),
        .pc_reg      (pc_reg),
        .update_en   (update_en),
        .kind_ex     (kind_ex),
        .taken_ex    (taken_ex),
        .pc_hashed   (pc_hashed),
        .pc_bh_hashed(pc_bh_hashed)
    );

    npc_predictor #(
        .gh_width  (gh_width),
        .stack_len (stack_len),
        .addr_width(addr_width)
    ) u_npc_predictor (
        .clk            (clk),
        .rstn           (rstn),
        .stall          (stall),
        .update_en      (update_en),
        .npc_ex         (npc_ex),
        .pc_ex_bh_hashed(pc_ex_bh_hashed),
        .pc_ex_hashed   (pc_ex_hashed),
        .kind_ex        (kind_ex),
        .choice_real    (choice_real),
        .ret_pc_ex      (ret_pc_ex),
        .choice_pdch_ex (choice_pdch_ex),
        .mis_pdc        (mis_pdc),
        .npc_pdc        (npc_pdc),
        .kind_pdc       (kind_pdc),
        .taken_pdc      (taken_pdc),
        .choice_btb_ras (choice_btb_ras),
        .choice_pdch    (choice_pdch),
        .pc_bh_hashed   (pc_bh_hashed),
        .pc_hashed      (pc_hashed),
        .pc_reg         (pc_reg)
    );

endmodule

//--- src/npc_predictor.sv
`timescale 1ns/1ps

module npc_predictor #(
    parameter int gh_width   = bpu_cfg_pkg::default_gh_width,
    parameter int stack_len  = bpu_cfg_pkg::default_stack_len,
    parameter int addr_width = bpu_cfg_pkg::default_addr_width
) (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       stall,
    input  logic                       update_en,
    input  logic [addr_width-1:0]      npc_ex,
    input  logic [gh_width-1:0]        pc_ex_bh_hashed,
    input  logic [gh_width-1:0]        pc_ex_hashed,
    input  bpu_kind_pkg::branch_kind_t kind_ex,
    input  logic                       choice_real,
    input  logic [addr_width-1:0]      ret_pc_ex,
    input  bpu_cfg_pkg::choice_ctr_t   choice_pdch_ex,
    input  logic                       mis_pdc,
    output logic [addr_width-1:0]      npc_pdc,
    input  bpu_kind_pkg::branch_kind_t kind_pdc,
    input  logic                       taken_pdc,
    output logic                       choice_btb_ras,
    output bpu_cfg_pkg::choice_ctr_t   choice_pdch,
    input  logic [gh_width-1:0]        pc_bh_hashed,
    input  logic [gh_width-1:0]        pc_hashed,
    input  logic [addr_width-1:0]      pc_reg
);
    import bpu_kind_pkg::*;

    logic [addr_width-1:0] npc_btb;
    logic [addr_width-1:0] npc_ras;
    logic [addr_width-1:0] npc_seq;
    logic [addr_width-1:0] npc_btb_or_seq;
    logic                  btb_hit;
    logic                  btb_update;
    logic                  cpht_update;
    logic                  ret_pop_pdc;

    // execute side strobes
    assign btb_update  = update_en && kind_is_branch(kind_ex);
    assign cpht_update = update_en && (kind_ex == ret);

    // speculative pop on a taken, unstalled ret
    assign ret_pop_pdc = !stall && taken_pdc && (kind_pdc == ret);

    // fall-through to the next aligned pair
    assign npc_seq = pc_reg + (pc_reg[0] ? addr_width'(1) : addr_width'(2));
    assign npc_btb_or_seq = btb_hit ? npc_btb : npc_seq;

    btb #(
        .gh_width  (gh_width),
        .addr_width(addr_width)
    ) u_btb (
        .clk             (clk),
        .rstn            (rstn),
        .hashed_pc       (pc_bh_hashed),
        .npc_pdc         (npc_btb),
        .hit             (btb_hit),
        .hashed_pc_update(pc_ex_bh_hashed),
        .npc_real        (npc_ex),
        .update_en       (btb_update)
    );

    ras #(
        .stack_len (stack_len),
        .addr_width(addr_width)
    ) u_ras (
        .clk        (clk),
        .rstn       (rstn),
        .call_ex    (kind_ex == call),
        .ret_ex     (kind_ex == ret),
        .ret_pc_ex  (ret_pc_ex),
        .ret_pop_pdc(ret_pop_pdc),
        .mis_pdc    (mis_pdc),
        .update_en  (update_en),
        .ret_pc_pdc (npc_ras)
    );

    cpht #(
        .ch_width(gh_width)
    ) u_cpht (
        .clk             (clk),
        .rstn            (rstn),
        .hashed_pc       (pc_hashed),
        .choice_pdc      (choice_btb_ras),
        .choice_pdch     (choice_pdch),
        .hashed_pc_update(pc_ex_hashed),
        .choice_real     (choice_real),
        .choice_pdch_ex  (choice_pdch_ex),
        .update_en       (cpht_update)
    );

    always_comb begin
        if (stall) begin
            npc_pdc = pc_reg;
        end else if (!taken_pdc) begin
            npc_pdc = npc_seq;
        end else begin
            case (kind_pdc)
                direct_jump, indirect_jump, jump, call: npc_pdc = npc_btb_or_seq;
                // counter msb decides between btb and ras
                ret: npc_pdc = choice_btb_ras ? npc_btb_or_seq : npc_ras;
                default: npc_pdc = npc_seq;
            endcase
        end
    end

endmodule

//--- src/cpht.sv
`timescale 1ns/1ps

module cpht #(
    parameter int ch_width = bpu_cfg_pkg::default_gh_width
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic [ch_width-1:0]      hashed_pc,
    output logic                     choice_pdc,
    output bpu_cfg_pkg::choice_ctr_t choice_pdch,
    input  logic [ch_width-1:0]      hashed_pc_update,
    input  logic                     choice_real,
    input  bpu_cfg_pkg::choice_ctr_t choice_pdch_ex,
    input  logic                     update_en
);
    import bpu_cfg_pkg::*;

    localparam int depth = 1 << ch_width;

    choice_ctr_t      ctr_mem [depth];
    logic [depth-1:0] valid;
    choice_ctr_t      ctr_next;

    // unwritten entries read as weak ras
    assign choice_pdch = valid[hashed_pc] ? ctr_mem[hashed_pc] : choice_init;

    // msb picks btb over ras
    assign choice_pdc = choice_pdch[1];

    // step the value seen at prediction time, saturate at both ends
    always_comb begin
        ctr_next = choice_pdch_ex;
        if (choice_real) begin
            if (choice_pdch_ex != 2'd3) begin
                ctr_next = choice_pdch_ex + 2'd1;
            end
        end else if (choice_pdch_ex != 2'd0) begin
            ctr_next = choice_pdch_ex - 2'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (update_en) begin
            ctr_mem[hashed_pc_update] <= ctr_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= '0;
        end else if (update_en) begin
            valid[hashed_pc_update] <= 1'b1;
        end
    end

endmodule

//--- src/ras.sv
`timescale 1ns/1ps

module ras #(
    parameter int stack_len  = bpu_cfg_pkg::default_stack_len,
    parameter int addr_width = bpu_cfg_pkg::default_addr_width
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  call_ex,
    input  logic                  ret_ex,
    input  logic [addr_width-1:0] ret_pc_ex,
    input  logic                  ret_pop_pdc,
    input  logic                  mis_pdc,
    input  logic                  update_en,
    output logic [addr_width-1:0] ret_pc_pdc
);
    localparam int ptr_width = $clog2(stack_len);

    logic [addr_width-1:0] stack_mem [stack_len];
    logic [ptr_width-1:0]  cmt_ptr;
    logic [ptr_width-1:0]  cmt_ptr_next;
    logic [ptr_width-1:0]  spec_ptr;
    logic [ptr_width-1:0]  spec_top;
    logic                  push;
    logic                  commit_pop;

    assign push       = update_en && call_ex;
    assign commit_pop = update_en && ret_ex;

    // pointers address the next free slot
    assign spec_top   = spec_ptr - 1'b1;
    assign ret_pc_pdc = stack_mem[spec_top];

    always_comb begin
        cmt_ptr_next = cmt_ptr;
        if (push) begin
            cmt_ptr_next = cmt_ptr + 1'b1;
        end else if (commit_pop) begin
            cmt_ptr_next = cmt_ptr - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            stack_mem[cmt_ptr] <= ret_pc_ex;
        end
    end

    // committed ret does not touch spec_ptr, it was popped at fetch
    always_ff @(posedge clk) begin
        if (!rstn) begin
            cmt_ptr  <= '0;
            spec_ptr <= '0;
        end else begin
            cmt_ptr <= cmt_ptr_next;
            if (update_en && mis_pdc) begin
                // resync to the committed stack
                spec_ptr <= cmt_ptr_next;
            end else if (push && !ret_pop_pdc) begin
                spec_ptr <= spec_ptr + 1'b1;
            end else if (ret_pop_pdc && !push) begin
                spec_ptr <= spec_ptr - 1'b1;
            end
        end
    end

endmodule

//--- src/btb.sv
`timescale 1ns/1ps

module btb #(
    parameter int gh_width   = bpu_cfg_pkg::default_gh_width,
    parameter int addr_width = bpu_cfg_pkg::default_addr_width
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic [gh_width-1:0]   hashed_pc,
    output logic [addr_width-1:0] npc_pdc,
    output logic                  hit,
    input  logic [gh_width-1:0]   hashed_pc_update,
    input  logic [addr_width-1:0] npc_real,
    input  logic                  update_en
);
    localparam int depth = 1 << gh_width;

    logic [addr_width-1:0] target_mem [depth];
    logic [depth-1:0]      valid;

    // lookup in the fetch cycle
    assign npc_pdc = target_mem[hashed_pc];
    assign hit     = valid[hashed_pc];

    // target storage
    always_ff @(posedge clk) begin
        if (update_en) begin
            target_mem[hashed_pc_update] <= npc_real;
        end
    end

    // entry becomes valid on its first write
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid <= '0;
        end else if (update_en) begin
            valid[hashed_pc_update] <= 1'b1;
        end
    end

endmodule

//--- src/pc_hash.sv
`timescale 1ns/1ps

module pc_hash #(
    parameter int addr_width = bpu_cfg_pkg::default_addr_width,
    parameter int gh_width   = bpu_cfg_pkg::default_gh_width
) (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic [addr_width-1:0]      pc_reg,
    input  logic                       update_en,
    input  bpu_kind_pkg::branch_kind_t kind_ex,
    input  logic                       taken_ex,
    output logic [gh_width-1:0]        pc_hashed,
    output logic [gh_width-1:0]        pc_bh_hashed
);
    import bpu_kind_pkg::*;

    localparam int n_slices = (addr_width + gh_width - 1) / gh_width;

    logic [n_slices*gh_width-1:0] pc_ext;
    logic [gh_width-1:0]          ghr;

    // fold the address into gh_width bits, top slice zero padded
    always_comb begin
        pc_ext = '0;
        pc_ext[addr_width-1:0] = pc_reg;
        pc_hashed = '0;
        for (int i = 0; i < n_slices; i++) begin
            pc_hashed = pc_hashed ^ pc_ext[i*gh_width +: gh_width];
        end
    end

    assign pc_bh_hashed = pc_hashed ^ ghr;

    // committed outcomes only, newest in bit 0
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ghr <= '0;
        end else if (update_en && kind_is_branch(kind_ex)) begin
            ghr <= {ghr[gh_width-2:0], taken_ex};
        end
    end

endmodule

//--- src/bpu_cfg_pkg.sv
package bpu_cfg_pkg;

    // word address width, pairs of 32-bit words are fetched
    localparam int default_addr_width = 30;

    // history length, also the index width of btb and cpht
    localparam int default_gh_width = 14;

    // return stack depth, power of two
    localparam int default_stack_len = 16;

    // ras/btb choice counter
    // 0,1 trust the ras and 2,3 trust the btb
    typedef logic [1:0] choice_ctr_t;

    // weak ras, read for entries never written
    localparam choice_ctr_t choice_init = 2'd1;

endpackage

//--- src/bpu_kind_pkg.sv
package bpu_kind_pkg;

    // predecode and execute branch classes
    // 2 and 3 are spare codes and act as not_jump
    typedef enum logic [2:0] {
        not_jump      = 3'd0,
        direct_jump   = 3'd1,
        ret           = 3'd4,
        indirect_jump = 3'd5,
        call          = 3'd6,
        jump          = 3'd7
    } branch_kind_t;

    // true for every real control transfer
    function automatic logic kind_is_branch(branch_kind_t kind);
        case (kind)
            direct_jump, ret, indirect_jump, call, jump: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage
